// ==== verilog/pipeline_pkg.sv ====
package pipeline_pkg;

	// datapath and register file sizes
	localparam int data_w     = 8;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 1 << reg_addr_w;

	// instruction opcodes, codes 7..31 behave as op_nop
	typedef enum logic [4:0] {
		op_nop = 5'd0,
		op_add = 5'd1,
		op_sub = 5'd2,
		op_and = 5'd3,
		op_or  = 5'd4,
		op_xor = 5'd5,
		op_li  = 5'd6
	} opcode_e;

	// 20-bit instruction word, msb first
	typedef struct packed {
		opcode_e               opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
	} instr_t;

	// alu operations
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_e;

	typedef struct packed {
		logic    wr_en;
		alu_op_e alu_op;
	} ctrl_t;

	// decode-execute register
	typedef struct packed {
		logic                  valid;
		ctrl_t                 ctrl;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [data_w-1:0]     src_a;
		logic [data_w-1:0]     src_b;
	} de_stage_t;

	// execute-writeback register
	typedef struct packed {
		logic                  valid;
		logic [reg_addr_w-1:0] rd;
		logic [data_w-1:0]     data;
	} wb_stage_t;

endpackage

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [pipeline_pkg::reg_addr_w-1:0] rd_addr_a,
	input  logic [pipeline_pkg::reg_addr_w-1:0] rd_addr_b,
	output logic [pipeline_pkg::data_w-1:0]     rd_data_a,
	output logic [pipeline_pkg::data_w-1:0]     rd_data_b,
	input  logic                                wr_en,
	input  logic [pipeline_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [pipeline_pkg::data_w-1:0]     wr_data
);

	logic [pipeline_pkg::data_w-1:0] regs [pipeline_pkg::num_regs];

	// write port, the whole array clears on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < pipeline_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// read ports with write-through
	// covers an instruction two slots behind its producer
	assign rd_data_a = (wr_en && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (wr_en && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                instr_valid,
	input  pipeline_pkg::instr_t                instr,
	output logic [pipeline_pkg::reg_addr_w-1:0] rf_addr_a,
	output logic [pipeline_pkg::reg_addr_w-1:0] rf_addr_b,
	input  logic [pipeline_pkg::data_w-1:0]     rf_data_a,
	input  logic [pipeline_pkg::data_w-1:0]     rf_data_b,
	output pipeline_pkg::de_stage_t             de
);

	pipeline_pkg::ctrl_t             ctrl;
	logic                            is_op;
	logic                            is_li;
	logic [pipeline_pkg::data_w-1:0] imm;
	logic [pipeline_pkg::data_w-1:0] src_b;

	////////////////////////////////////////
	// operand fetch
	////////////////////////////////////////

	assign rf_addr_a = instr.rs1;
	assign rf_addr_b = instr.rs2;

	// immediate sits in the rs2 and rs1 fields
	assign imm   = instr[pipeline_pkg::data_w-1:0];
	assign is_li = (instr.opcode == pipeline_pkg::op_li);
	assign src_b = is_li ? imm : rf_data_b;

	////////////////////////////////////////
	// control decode
	////////////////////////////////////////

	always_comb begin
		is_op       = 1'b1;
		ctrl.alu_op = pipeline_pkg::alu_add;
		case (instr.opcode)
			pipeline_pkg::op_add: ctrl.alu_op = pipeline_pkg::alu_add;
			pipeline_pkg::op_sub: ctrl.alu_op = pipeline_pkg::alu_sub;
			pipeline_pkg::op_and: ctrl.alu_op = pipeline_pkg::alu_and;
			pipeline_pkg::op_or:  ctrl.alu_op = pipeline_pkg::alu_or;
			pipeline_pkg::op_xor: ctrl.alu_op = pipeline_pkg::alu_xor;
			pipeline_pkg::op_li:  ctrl.alu_op = pipeline_pkg::alu_pass_b;
			// op_nop and every undefined code
			default: is_op = 1'b0;
		endcase
		// r0 stays zero, so a write to it is dropped here
		ctrl.wr_en = is_op && (instr.rd != '0);
	end

	////////////////////////////////////////
	// decode-execute register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		de.ctrl  <= ctrl;
		de.rd    <= instr.rd;
		de.rs1   <= instr.rs1;
		de.rs2   <= instr.rs2;
		de.src_a <= rf_data_a;
		de.src_b <= src_b;
		if (rst) begin
			de.valid <= 1'b0;
		end else begin
			de.valid <= instr_valid;
		end
	end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  pipeline_pkg::de_stage_t de,
	output pipeline_pkg::wb_stage_t wb
);

	logic                            fwd_a;
	logic                            fwd_b;
	logic                            uses_imm;
	logic [pipeline_pkg::data_w-1:0] op_a;
	logic [pipeline_pkg::data_w-1:0] op_b;
	logic [pipeline_pkg::data_w-1:0] result;

	////////////////////////////////////////
	// forwarding
	////////////////////////////////////////

	// pass_b carries the immediate of op_li, never a register
	assign uses_imm = (de.ctrl.alu_op == pipeline_pkg::alu_pass_b);

	// the instruction just ahead sits in wb and has not reached the regfile yet
	// wb.valid is never set for rd 0, so r0 cannot match
	assign fwd_a = wb.valid && (wb.rd == de.rs1);
	assign fwd_b = wb.valid && (wb.rd == de.rs2) && !uses_imm;

	assign op_a = fwd_a ? wb.data : de.src_a;
	assign op_b = fwd_b ? wb.data : de.src_b;

	////////////////////////////////////////
	// alu
	////////////////////////////////////////

	// results wrap modulo 256
	always_comb begin
		case (de.ctrl.alu_op)
			pipeline_pkg::alu_add:    result = op_a + op_b;
			pipeline_pkg::alu_sub:    result = op_a - op_b;
			pipeline_pkg::alu_and:    result = op_a & op_b;
			pipeline_pkg::alu_or:     result = op_a | op_b;
			pipeline_pkg::alu_xor:    result = op_a ^ op_b;
			pipeline_pkg::alu_pass_b: result = op_b;
			default:                  result = op_b;
		endcase
	end

	////////////////////////////////////////
	// execute-writeback register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		wb.rd   <= de.rd;
		wb.data <= result;
		if (rst) begin
			wb.valid <= 1'b0;
		end else begin
			// bubbles, nops and writes to r0 leave wb idle
			wb.valid <= de.valid && de.ctrl.wr_en;
		end
	end

endmodule

// ==== verilog/pipeline_top.sv ====
`timescale 1ns/1ps

module pipeline_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    instr_valid,
	input  pipeline_pkg::instr_t    instr,
	output pipeline_pkg::wb_stage_t wb
);

	// decode to regfile read ports
	logic [pipeline_pkg::reg_addr_w-1:0] rf_addr_a;
	logic [pipeline_pkg::reg_addr_w-1:0] rf_addr_b;
	logic [pipeline_pkg::data_w-1:0]     rf_data_a;
	logic [pipeline_pkg::data_w-1:0]     rf_data_b;

	// decode to execute
	pipeline_pkg::de_stage_t de;

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	decode_stage decode_i (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rf_addr_a   (rf_addr_a),
		.rf_addr_b   (rf_addr_b),
		.rf_data_a   (rf_data_a),
		.rf_data_b   (rf_data_b),
		.de          (de)
	);

	// write port fed straight from the wb register
	regfile regfile_i (
		.clk       (clk),
		.rst       (rst),
		.rd_addr_a (rf_addr_a),
		.rd_addr_b (rf_addr_b),
		.rd_data_a (rf_data_a),
		.rd_data_b (rf_data_b),
		.wr_en     (wb.valid),
		.wr_addr   (wb.rd),
		.wr_data   (wb.data)
	);

	////////////////////////////////////////
	// execute and writeback
	////////////////////////////////////////

	execute_stage execute_i (
		.clk (clk),
		.rst (rst),
		.de  (de),
		.wb  (wb)
	);

endmodule

// ==== sim/pipeline_assert.sv ====
`timescale 1ns/1ps

module pipeline_assert (
	input logic                    clk,
	input logic                    rst,
	input logic                    de_valid,
	input pipeline_pkg::wb_stage_t wb
);

	////////////////////////////////////////
	// writeback properties
	////////////////////////////////////////

	// quiet in reset and on the first cycle out of it
	wb_quiet_after_reset: assert property (@(posedge clk) rst |=> (!wb.valid ##1 !wb.valid))
		else $error("wb.valid set during or right after reset");

	// r0 is never written
	wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst) wb.valid |-> (wb.rd != '0))
		else $error("wb.valid set with rd 0");

	// every result comes from a valid decode one cycle earlier
	wb_follows_de: assert property (@(posedge clk) disable iff (rst) wb.valid |-> $past(de_valid))
		else $error("wb.valid without a valid decode stage before it");

endmodule

bind pipeline_top pipeline_assert assert_i (
	.clk      (clk),
	.rst      (rst),
	.de_valid (de.valid),
	.wb       (wb)
);

// ==== sim/pipeline_tb.sv ====
`timescale 1ns/1ps

module pipeline_tb;

	localparam int clk_period   = 4;
	localparam int reset_cycles = 16;
	localparam int n_random     = 200;
	localparam int flush_rows   = 2;
	localparam int margin       = 50;

	// table row whose expected wb belongs to the row two cycles earlier
	typedef struct packed {
		logic                    valid;
		pipeline_pkg::instr_t    instr;
		pipeline_pkg::wb_stage_t exp;
	} row_t;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    instr_valid;
	pipeline_pkg::instr_t    instr;
	pipeline_pkg::wb_stage_t wb;

	row_t                    table_q[$];
	pipeline_pkg::wb_stage_t exp_q[$];
	logic [7:0]              ref_regs [32];
	logic                    table_ready = 1'b0;
	int                      seed;

	pipeline_top dut_i (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb)
	);

	always #(clk_period / 2) clk = ~clk;

	////////////////////////////////////////
	// instruction builders and reference model
	////////////////////////////////////////

	function automatic pipeline_pkg::instr_t mk_instr(input logic [4:0] op, input logic [4:0] rd,
		input logic [4:0] rs2, input logic [4:0] rs1);
		return {op, rd, rs2, rs1};
	endfunction

	// immediate occupies the low 8 bits of the word
	function automatic pipeline_pkg::instr_t li_instr(input logic [4:0] rd, input logic [7:0] imm);
		return {pipeline_pkg::op_li, rd, 2'b00, imm};
	endfunction

	function automatic logic [7:0] imm_for(input logic [4:0] r);
		return {3'b000, r} * 8'd37 + 8'd11;
	endfunction

	// register model updated in program order
	task automatic predict(input logic valid, input pipeline_pkg::instr_t ins,
		output pipeline_pkg::wb_stage_t exp);
		logic [4:0] code;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] res;
		logic       wr;
		code = ins[19:15];
		a    = ref_regs[ins[4:0]];
		b    = ref_regs[ins[9:5]];
		wr   = 1'b1;
		res  = 8'h00;
		case (code)
			5'd1: res = a + b;
			5'd2: res = a - b;
			5'd3: res = a & b;
			5'd4: res = a | b;
			5'd5: res = a ^ b;
			5'd6: res = ins[7:0];
			default: wr = 1'b0;
		endcase
		if (ins[14:10] == 5'd0) begin
			wr = 1'b0;
		end
		exp.valid = valid && wr;
		exp.rd    = ins[14:10];
		exp.data  = res;
		if (exp.valid) begin
			ref_regs[ins[14:10]] = res;
		end
	endtask

	task automatic add_row(input logic valid, input pipeline_pkg::instr_t ins);
		row_t                    row;
		pipeline_pkg::wb_stage_t exp;
		predict(valid, ins, exp);
		exp_q.push_back(exp);
		row.valid = valid;
		row.instr = ins;
		row.exp   = exp_q.pop_front();
		table_q.push_back(row);
	endtask

	////////////////////////////////////////
	// drive and check
	////////////////////////////////////////

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	// outputs are checked 1 ns after the edge and the next row is driven right after
	task automatic drive_and_check(input logic valid, input pipeline_pkg::instr_t ins,
		input pipeline_pkg::wb_stage_t exp);
		@(posedge clk);
		#1;
		assert (wb.valid === exp.valid) else
			report_error($sformatf("Fail wb.valid expected 0x%h actual 0x%h", exp.valid, wb.valid));
		if (exp.valid) begin
			assert (wb.rd === exp.rd) else
				report_error($sformatf("Fail wb.rd expected 0x%h actual 0x%h", exp.rd, wb.rd));
			assert (wb.data === exp.data) else
				report_error($sformatf("Fail wb.data expected 0x%h actual 0x%h", exp.data, wb.data));
		end
		instr_valid = valid;
		instr       = ins;
	endtask

	task automatic run_instr(input logic valid, input pipeline_pkg::instr_t ins);
		pipeline_pkg::wb_stage_t exp;
		pipeline_pkg::wb_stage_t due;
		predict(valid, ins, exp);
		exp_q.push_back(exp);
		due = exp_q.pop_front();
		drive_and_check(valid, ins, due);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		logic [31:0]          rnd;
		logic                 valid;
		logic [4:0]           code;
		pipeline_pkg::instr_t ins;
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		seed        = 76;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = 8'h00;
		end
		exp_q.push_back('0);
		exp_q.push_back('0);

		// nop, writes to r0 and an idle cycle leave wb quiet
		add_row(1'b1, mk_instr(pipeline_pkg::op_nop, 5'd3, 5'd1, 5'd2));
		add_row(1'b1, mk_instr(pipeline_pkg::op_add, 5'd0, 5'd1, 5'd2));
		add_row(1'b1, li_instr(5'd0, 8'h5a));
		add_row(1'b0, li_instr(5'd5, 8'h77));

		// registers read zero out of reset
		add_row(1'b1, mk_instr(pipeline_pkg::op_or, 5'd7, 5'd30, 5'd31));

		// load every register, then read each back through or with r0
		for (int r = 1; r < 32; r++) begin
			add_row(1'b1, li_instr(r[4:0], imm_for(r[4:0])));
		end
		for (int r = 1; r < 32; r++) begin
			add_row(1'b1, mk_instr(pipeline_pkg::op_or, r[4:0], 5'd0, r[4:0]));
		end

		// alu opcodes with wrap around
		add_row(1'b1, li_instr(5'd1, 8'hff));
		add_row(1'b1, li_instr(5'd2, 8'h01));
		add_row(1'b1, mk_instr(pipeline_pkg::op_add, 5'd3, 5'd2, 5'd1));
		add_row(1'b1, li_instr(5'd4, 8'h05));
		add_row(1'b1, li_instr(5'd5, 8'h09));
		add_row(1'b1, mk_instr(pipeline_pkg::op_sub, 5'd6, 5'd5, 5'd4));
		add_row(1'b1, li_instr(5'd8, 8'h3c));
		add_row(1'b1, mk_instr(pipeline_pkg::op_and, 5'd9, 5'd8, 5'd6));
		add_row(1'b1, mk_instr(pipeline_pkg::op_or, 5'd10, 5'd2, 5'd8));
		add_row(1'b1, mk_instr(pipeline_pkg::op_xor, 5'd11, 5'd8, 5'd6));
		add_row(1'b1, mk_instr(pipeline_pkg::op_sub, 5'd12, 5'd1, 5'd2));

		// dependent chain at distance 1, 2 and 3
		add_row(1'b1, li_instr(5'd13, 8'h01));
		add_row(1'b1, mk_instr(pipeline_pkg::op_add, 5'd13, 5'd13, 5'd13));
		add_row(1'b1, mk_instr(pipeline_pkg::op_add, 5'd13, 5'd13, 5'd13));
		add_row(1'b0, '0);
		add_row(1'b1, mk_instr(pipeline_pkg::op_add, 5'd14, 5'd13, 5'd13));
		add_row(1'b0, '0);
		add_row(1'b0, '0);
		add_row(1'b1, mk_instr(pipeline_pkg::op_add, 5'd15, 5'd13, 5'd14));
		add_row(1'b1, mk_instr(pipeline_pkg::op_xor, 5'd16, 5'd14, 5'd15));

		// undefined codes change nothing
		add_row(1'b1, mk_instr(5'd7, 5'd1, 5'd2, 5'd3));
		add_row(1'b1, mk_instr(5'd31, 5'd2, 5'd0, 5'd0));
		add_row(1'b1, mk_instr(pipeline_pkg::op_or, 5'd1, 5'd0, 5'd1));
		add_row(1'b1, mk_instr(pipeline_pkg::op_or, 5'd2, 5'd0, 5'd2));
		table_ready = 1'b1;

		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b0;

		foreach (table_q[i]) begin
			drive_and_check(table_q[i].valid, table_q[i].instr, table_q[i].exp);
		end

		// random phase on r0..r7 so that dependencies are frequent
		for (int i = 0; i < n_random; i++) begin
			rnd   = $random(seed);
			valid = (rnd[1:0] != 2'b00);
			code  = {2'b00, rnd[4:2]};
			if (code == 5'd6) begin
				ins = mk_instr(code, {2'b00, rnd[7:5]}, rnd[12:8], rnd[17:13]);
			end else begin
				ins = mk_instr(code, {2'b00, rnd[7:5]}, {2'b00, rnd[10:8]}, {2'b00, rnd[13:11]});
			end
			run_instr(valid, ins);
		end

		// drain the last two results
		for (int i = 0; i < flush_rows; i++) begin
			run_instr(1'b0, '0);
		end

		$display("All tests passed");
		$finish;
	end

	////////////////////////////////////////
	// watchdog
	////////////////////////////////////////

	initial begin
		wait (table_ready);
		#((table_q.size() + n_random + flush_rows + reset_cycles + margin) * clk_period);
		$display("Simulation timed out before all instructions were checked");
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== pipeline.f ====
verilog/pipeline_pkg.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/pipeline_top.sv
sim/pipeline_assert.sv
sim/pipeline_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator
status=0
rm -f sim.log
verilator --binary --assert --timing --top-module pipeline_tb -f pipeline.f -o pipeline_sim \
	|| exit 1
./obj_dir/pipeline_sim > sim.log 2>&1 || status=1
cat sim.log
grep -q "Some tests failed" sim.log && status=1
[ "$status" -eq 0 ] && echo "simulation passed" || echo "simulation failed"
exit $status
